// File: logic/ao_periph_pkg.sv
/*
 * Always-on peripheral package with the address map, register offsets,
 * shared widths and the byte-enable merge used by every register block
 */
package ao_periph_pkg;

  localparam int WINDOW_BITS   = 12;
  localparam int NUM_FAST_INTR = 15;

  typedef logic [31:0]              word_t;
  typedef logic [3:0]               be_t;
  typedef logic [NUM_FAST_INTR-1:0] fast_intr_t;
  typedef logic [15:0]              prescale_t;

  // Decoded target of an internal register access
  typedef enum logic [1:0] {
    SEL_SOC_CTRL,
    SEL_TIMER,
    SEL_FAST_INTR,
    SEL_NONE
  } periph_sel_e;

  localparam word_t SOC_CTRL_BASE  = 32'h0000_0000;
  localparam word_t TIMER_BASE     = 32'h0000_1000;
  localparam word_t FAST_INTR_BASE = 32'h0000_2000;

  // soc_ctrl window
  localparam logic [WINDOW_BITS-1:0] SOC_EXIT_VALID_OFS   = 12'h000;
  localparam logic [WINDOW_BITS-1:0] SOC_EXIT_VALUE_OFS   = 12'h004;
  localparam logic [WINDOW_BITS-1:0] SOC_BOOT_SEL_OFS     = 12'h008;
  localparam logic [WINDOW_BITS-1:0] SOC_USE_SPIMEMIO_OFS = 12'h00C;

  // timer window
  localparam logic [WINDOW_BITS-1:0] TMR_CTRL_OFS     = 12'h000;
  localparam logic [WINDOW_BITS-1:0] TMR_PRESCALE_OFS = 12'h004;
  localparam logic [WINDOW_BITS-1:0] TMR_COMPARE_OFS  = 12'h008;
  localparam logic [WINDOW_BITS-1:0] TMR_COUNT_OFS    = 12'h00C;
  localparam logic [WINDOW_BITS-1:0] TMR_STATUS_OFS   = 12'h010;

  // fast_intr_ctrl window
  localparam logic [WINDOW_BITS-1:0] FIC_PENDING_OFS = 12'h000;
  localparam logic [WINDOW_BITS-1:0] FIC_ENABLE_OFS  = 12'h004;

  // Replaces the enabled bytes of old_val with those of new_val
  function automatic word_t apply_be(word_t old_val, word_t new_val, be_t be);
    word_t res;
    res = old_val;
    for (int i = 0; i < 4; i++) begin
      if (be[i]) begin
        res[8*i +: 8] = new_val[8*i +: 8];
      end
    end
    return res;
  endfunction

endpackage : ao_periph_pkg

// File: logic/obi_reg_bridge.sv
/*
 * OBI slave to single-cycle register bus bridge, grants at once and
 * returns the registered response one cycle later
 */
`timescale 1ns/100ps

module obi_reg_bridge
  import ao_periph_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_i,

  input  logic  req_i,
  input  word_t addr_i,
  input  logic  we_i,
  input  be_t   be_i,
  input  word_t wdata_i,
  output logic  gnt_o,
  output logic  rvalid_o,
  output word_t rdata_o,
  output logic  err_o,

  output logic  reg_valid_o,
  output logic  reg_we_o,
  output word_t reg_addr_o,
  output be_t   reg_be_o,
  output word_t reg_wdata_o,
  input  word_t reg_rdata_i,
  input  logic  reg_error_i
);

  logic  rvalid_q;
  logic  err_q;
  word_t rdata_q;

  // No back-pressure, every request is granted and issued in the same cycle
  assign gnt_o       = req_i;
  assign reg_valid_o = req_i;
  assign reg_we_o    = we_i;
  assign reg_addr_o  = addr_i;
  assign reg_be_o    = be_i;
  assign reg_wdata_o = wdata_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      rvalid_q <= req_i;
      err_q    <= req_i & reg_error_i;
    end
  end

  // Writes answer with zero data
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rdata_q <= '0;
    end else if (req_i) begin
      rdata_q <= we_i ? '0 : reg_rdata_i;
    end
  end

  assign rvalid_o = rvalid_q;
  assign err_o    = err_q;
  assign rdata_o  = rdata_q;

endmodule : obi_reg_bridge

// File: logic/ao_reg_demux.sv
/*
 * Register bus demux, decodes the 4 KiB window and steers the access
 * to one peripheral, returning its read data or an error
 */
`timescale 1ns/100ps

module ao_reg_demux
  import ao_periph_pkg::*;
(
  input  logic  reg_valid_i,
  input  word_t reg_addr_i,

  output logic  soc_valid_o,
  output logic  tmr_valid_o,
  output logic  fic_valid_o,

  input  word_t soc_rdata_i,
  input  word_t tmr_rdata_i,
  input  word_t fic_rdata_i,

  output word_t reg_rdata_o,
  output logic  reg_error_o
);

  periph_sel_e sel;

  // Window picked by the bits above the offset
  always_comb begin
    if (reg_addr_i[31:WINDOW_BITS] == SOC_CTRL_BASE[31:WINDOW_BITS]) begin
      sel = SEL_SOC_CTRL;
    end else if (reg_addr_i[31:WINDOW_BITS] == TIMER_BASE[31:WINDOW_BITS]) begin
      sel = SEL_TIMER;
    end else if (reg_addr_i[31:WINDOW_BITS] == FAST_INTR_BASE[31:WINDOW_BITS]) begin
      sel = SEL_FAST_INTR;
    end else begin
      sel = SEL_NONE;
    end
  end

  assign soc_valid_o = reg_valid_i && (sel == SEL_SOC_CTRL);
  assign tmr_valid_o = reg_valid_i && (sel == SEL_TIMER);
  assign fic_valid_o = reg_valid_i && (sel == SEL_FAST_INTR);

  always_comb begin
    case (sel)
      SEL_SOC_CTRL:  reg_rdata_o = soc_rdata_i;
      SEL_TIMER:     reg_rdata_o = tmr_rdata_i;
      SEL_FAST_INTR: reg_rdata_o = fic_rdata_i;
      default:       reg_rdata_o = '0;
    endcase
  end

  assign reg_error_o = reg_valid_i && (sel == SEL_NONE);

endmodule : ao_reg_demux

// File: logic/soc_ctrl.sv
/*
 * SoC control registers, exit status to the host, boot select readback
 * and the flash execution select
 */
`timescale 1ns/100ps

module soc_ctrl
  import ao_periph_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   valid_i,
  input  logic                   we_i,
  input  logic [WINDOW_BITS-1:0] offset_i,
  input  be_t                    be_i,
  input  word_t                  wdata_i,
  output word_t                  rdata_o,
  input  logic                   boot_select_i,
  input  logic                   execute_from_flash_i,
  output logic                   exit_valid_o,
  output word_t                  exit_value_o,
  output logic                   use_spimemio_o
);

  logic  wr;
  logic  exit_valid_q;
  word_t exit_value_q;
  logic  use_spimemio_q;

  assign wr = valid_i & we_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      exit_valid_q   <= 1'b0;
      exit_value_q   <= '0;
      // Strap sampled while reset is held
      use_spimemio_q <= execute_from_flash_i;
    end else if (wr) begin
      if (offset_i == SOC_EXIT_VALID_OFS && be_i[0]) begin
        exit_valid_q <= wdata_i[0];
      end
      if (offset_i == SOC_EXIT_VALUE_OFS) begin
        exit_value_q <= apply_be(exit_value_q, wdata_i, be_i);
      end
      if (offset_i == SOC_USE_SPIMEMIO_OFS && be_i[0]) begin
        use_spimemio_q <= wdata_i[0];
      end
    end
  end

  always_comb begin
    case (offset_i)
      SOC_EXIT_VALID_OFS:   rdata_o = word_t'(exit_valid_q);
      SOC_EXIT_VALUE_OFS:   rdata_o = exit_value_q;
      SOC_BOOT_SEL_OFS:     rdata_o = word_t'(boot_select_i);
      SOC_USE_SPIMEMIO_OFS: rdata_o = word_t'(use_spimemio_q);
      default:              rdata_o = '0;
    endcase
  end

  assign exit_valid_o   = exit_valid_q;
  assign exit_value_o   = exit_value_q;
  assign use_spimemio_o = use_spimemio_q;

endmodule : soc_ctrl

// File: logic/fast_intr_ctrl.sv
/*
 * Fast interrupt controller, latches the lines into sticky pending bits
 * and masks them with a per-line enable
 */
`timescale 1ns/100ps

module fast_intr_ctrl
  import ao_periph_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   valid_i,
  input  logic                   we_i,
  input  logic [WINDOW_BITS-1:0] offset_i,
  input  be_t                    be_i,
  input  word_t                  wdata_i,
  output word_t                  rdata_o,
  input  fast_intr_t             fast_intr_i,
  output fast_intr_t             fast_intr_o
);

  logic       wr;
  word_t      clr_word;
  word_t      enable_word;
  fast_intr_t pending_clr;
  fast_intr_t pending_q;
  fast_intr_t enable_q;

  assign wr = valid_i & we_i;

  // Write-1-to-clear mask, only from the enabled bytes
  assign clr_word    = apply_be('0, wdata_i, be_i);
  assign pending_clr = (wr && offset_i == FIC_PENDING_OFS) ?
                       clr_word[NUM_FAST_INTR-1:0] : '0;
  assign enable_word = apply_be(word_t'(enable_q), wdata_i, be_i);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pending_q <= '0;
      enable_q  <= '0;
    end else begin
      // A new edge beats a clear in the same cycle
      pending_q <= (pending_q & ~pending_clr) | fast_intr_i;
      if (wr && offset_i == FIC_ENABLE_OFS) begin
        enable_q <= enable_word[NUM_FAST_INTR-1:0];
      end
    end
  end

  always_comb begin
    case (offset_i)
      FIC_PENDING_OFS: rdata_o = word_t'(pending_q);
      FIC_ENABLE_OFS:  rdata_o = word_t'(enable_q);
      default:         rdata_o = '0;
    endcase
  end

  assign fast_intr_o = pending_q & enable_q;

endmodule : fast_intr_ctrl

// File: logic/timer_regs.sv
/*
 * Timer register block, control, prescale, compare and count load,
 * plus the sticky expired status that drives the interrupt
 */
`timescale 1ns/100ps

module timer_regs
  import ao_periph_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   valid_i,
  input  logic                   we_i,
  input  logic [WINDOW_BITS-1:0] offset_i,
  input  be_t                    be_i,
  input  word_t                  wdata_i,
  output word_t                  rdata_o,
  input  word_t                  count_i,
  input  logic                   match_i,
  output logic                   enable_o,
  output prescale_t              prescale_o,
  output word_t                  compare_o,
  output logic                   load_o,
  output word_t                  load_value_o,
  output logic                   intr_o
);

  logic      wr;
  logic      status_clr;
  word_t     ctrl_word;
  word_t     prescale_word;
  logic [1:0] ctrl_q;
  prescale_t prescale_q;
  word_t     compare_q;
  logic      expired_q;

  assign wr = valid_i & we_i;

  assign ctrl_word     = apply_be(word_t'(ctrl_q), wdata_i, be_i);
  assign prescale_word = apply_be(word_t'(prescale_q), wdata_i, be_i);
  assign status_clr    = wr && offset_i == TMR_STATUS_OFS && be_i[0] && wdata_i[0];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ctrl_q     <= '0;
      prescale_q <= '0;
      compare_q  <= '0;
      expired_q  <= 1'b0;
    end else begin
      if (wr && offset_i == TMR_CTRL_OFS) begin
        ctrl_q <= ctrl_word[1:0];
      end
      if (wr && offset_i == TMR_PRESCALE_OFS) begin
        prescale_q <= prescale_word[15:0];
      end
      if (wr && offset_i == TMR_COMPARE_OFS) begin
        compare_q <= apply_be(compare_q, wdata_i, be_i);
      end
      // Match has priority over the clear
      expired_q <= match_i | (expired_q & ~status_clr);
    end
  end

  // Count write goes straight to the core, merged with the live count
  assign load_o       = wr && offset_i == TMR_COUNT_OFS;
  assign load_value_o = apply_be(count_i, wdata_i, be_i);

  always_comb begin
    case (offset_i)
      TMR_CTRL_OFS:     rdata_o = word_t'(ctrl_q);
      TMR_PRESCALE_OFS: rdata_o = word_t'(prescale_q);
      TMR_COMPARE_OFS:  rdata_o = compare_q;
      TMR_COUNT_OFS:    rdata_o = count_i;
      TMR_STATUS_OFS:   rdata_o = word_t'(expired_q);
      default:          rdata_o = '0;
    endcase
  end

  assign enable_o   = ctrl_q[0];
  assign prescale_o = prescale_q;
  assign compare_o  = compare_q;
  assign intr_o     = expired_q & ctrl_q[1];

endmodule : timer_regs

// File: logic/timer_core.sv
/*
 * Timer counting logic, prescaler tick every prescale+1 cycles and a
 * 32-bit up counter with a one-cycle compare match
 */
`timescale 1ns/100ps

module timer_core
  import ao_periph_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_i,
  input  logic      enable_i,
  input  prescale_t prescale_i,
  input  word_t     compare_i,
  input  logic      load_i,
  input  word_t     load_value_i,
  output word_t     count_o,
  output logic      match_o
);

  prescale_t presc_q;
  word_t     count_q;
  word_t     count_next;
  logic      match_q;
  logic      tick;

  // >= also catches a prescale lowered below the running value
  assign tick       = enable_i && (presc_q >= prescale_i);
  assign count_next = count_q + 32'd1;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      presc_q <= '0;
      count_q <= '0;
      match_q <= 1'b0;
    end else begin
      match_q <= 1'b0;
      if (load_i) begin
        count_q <= load_value_i;
        presc_q <= '0;
      end else if (tick) begin
        presc_q <= '0;
        count_q <= count_next;
        match_q <= (count_next == compare_i);
      end else if (enable_i) begin
        presc_q <= presc_q + 16'd1;
      end
    end
  end

  assign count_o = count_q;
  assign match_o = match_q;

endmodule : timer_core

// File: logic/ao_peripheral_subsystem.sv
/*
 * Always-on peripheral subsystem, OBI slave bridged onto a register bus
 * serving soc_ctrl, the timer and the fast interrupt controller
 */
`timescale 1ns/100ps

module ao_peripheral_subsystem
  import ao_periph_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_i,

  input  logic       slave_req_i,
  output logic       slave_gnt_o,
  input  word_t      slave_addr_i,
  input  logic       slave_we_i,
  input  be_t        slave_be_i,
  input  word_t      slave_wdata_i,
  output logic       slave_rvalid_o,
  output word_t      slave_rdata_o,
  output logic       slave_err_o,

  input  logic       boot_select_i,
  input  logic       execute_from_flash_i,
  output logic       exit_valid_o,
  output word_t      exit_value_o,
  output logic       use_spimemio_o,

  input  fast_intr_t fast_intr_i,
  output fast_intr_t fast_intr_o,
  output logic       timer_intr_o
);

  logic      reg_valid;
  logic      reg_we;
  word_t     reg_addr;
  be_t       reg_be;
  word_t     reg_wdata;
  word_t     reg_rdata;
  logic      reg_error;

  logic      soc_valid;
  logic      tmr_valid;
  logic      fic_valid;
  word_t     soc_rdata;
  word_t     tmr_rdata;
  word_t     fic_rdata;

  logic      tmr_enable;
  prescale_t tmr_prescale;
  word_t     tmr_compare;
  logic      tmr_load;
  word_t     tmr_load_value;
  word_t     tmr_count;
  logic      tmr_match;

  obi_reg_bridge obi_reg_bridge_i (
    .clk_i,
    .rst_i,
    .req_i       (slave_req_i),
    .addr_i      (slave_addr_i),
    .we_i        (slave_we_i),
    .be_i        (slave_be_i),
    .wdata_i     (slave_wdata_i),
    .gnt_o       (slave_gnt_o),
    .rvalid_o    (slave_rvalid_o),
    .rdata_o     (slave_rdata_o),
    .err_o       (slave_err_o),
    .reg_valid_o (reg_valid),
    .reg_we_o    (reg_we),
    .reg_addr_o  (reg_addr),
    .reg_be_o    (reg_be),
    .reg_wdata_o (reg_wdata),
    .reg_rdata_i (reg_rdata),
    .reg_error_i (reg_error)
  );

  ao_reg_demux ao_reg_demux_i (
    .reg_valid_i (reg_valid),
    .reg_addr_i  (reg_addr),
    .soc_valid_o (soc_valid),
    .tmr_valid_o (tmr_valid),
    .fic_valid_o (fic_valid),
    .soc_rdata_i (soc_rdata),
    .tmr_rdata_i (tmr_rdata),
    .fic_rdata_i (fic_rdata),
    .reg_rdata_o (reg_rdata),
    .reg_error_o (reg_error)
  );

  soc_ctrl soc_ctrl_i (
    .clk_i,
    .rst_i,
    .valid_i  (soc_valid),
    .we_i     (reg_we),
    .offset_i (reg_addr[WINDOW_BITS-1:0]),
    .be_i     (reg_be),
    .wdata_i  (reg_wdata),
    .rdata_o  (soc_rdata),
    .boot_select_i,
    .execute_from_flash_i,
    .exit_valid_o,
    .exit_value_o,
    .use_spimemio_o
  );

  fast_intr_ctrl fast_intr_ctrl_i (
    .clk_i,
    .rst_i,
    .valid_i  (fic_valid),
    .we_i     (reg_we),
    .offset_i (reg_addr[WINDOW_BITS-1:0]),
    .be_i     (reg_be),
    .wdata_i  (reg_wdata),
    .rdata_o  (fic_rdata),
    .fast_intr_i,
    .fast_intr_o
  );

  timer_regs timer_regs_i (
    .clk_i,
    .rst_i,
    .valid_i      (tmr_valid),
    .we_i         (reg_we),
    .offset_i     (reg_addr[WINDOW_BITS-1:0]),
    .be_i         (reg_be),
    .wdata_i      (reg_wdata),
    .rdata_o      (tmr_rdata),
    .count_i      (tmr_count),
    .match_i      (tmr_match),
    .enable_o     (tmr_enable),
    .prescale_o   (tmr_prescale),
    .compare_o    (tmr_compare),
    .load_o       (tmr_load),
    .load_value_o (tmr_load_value),
    .intr_o       (timer_intr_o)
  );

  timer_core timer_core_i (
    .clk_i,
    .rst_i,
    .enable_i     (tmr_enable),
    .prescale_i   (tmr_prescale),
    .compare_i    (tmr_compare),
    .load_i       (tmr_load),
    .load_value_i (tmr_load_value),
    .count_o      (tmr_count),
    .match_o      (tmr_match)
  );

endmodule : ao_peripheral_subsystem

// File: bench/ao_peripheral_subsystem_tb.sv
/*
 * Testbench for the always-on peripheral subsystem, random OBI traffic
 * checked against a register model, plus fast interrupt and timer runs
 */
`timescale 1ns/100ps

module ao_peripheral_subsystem_tb;
  import ao_periph_pkg::*;

  localparam int N_RAND       = 300;
  localparam int N_FIC        = 150;
  localparam int N_BOOT       = 24;
  localparam int N_ACCESS     = N_RAND + N_FIC + N_BOOT + 40;
  localparam int TIMER_BUDGET = 120;

  logic       clk;
  logic       rst;
  logic       req;
  logic       gnt;
  word_t      addr;
  logic       we;
  be_t        be;
  word_t      wdata;
  logic       rvalid;
  word_t      rdata;
  logic       err;
  logic       boot_sel;
  logic       exec_flash;
  logic       exit_valid;
  word_t      exit_value;
  logic       use_spi;
  fast_intr_t fintr_in;
  fast_intr_t fintr_out;
  logic       tintr;

  // Register model
  logic       m_exit_valid;
  word_t      m_exit_value;
  logic       m_use_spi;
  fast_intr_t m_fic_pend;
  fast_intr_t m_fic_en;
  logic [1:0] m_tmr_ctrl;
  prescale_t  m_tmr_presc;
  word_t      m_tmr_cmp;
  logic       m_tmr_status;

  // Response due on the next cycle
  logic       pend_valid;
  logic       pend_check;
  logic       pend_err;
  word_t      pend_rdata;
  word_t      last_rdata;
  logic       nxt_boot;
  fast_intr_t nxt_fintr;
  integer     seed;

  ao_peripheral_subsystem dut0 (
    .clk_i                (clk),
    .rst_i                (rst),
    .slave_req_i          (req),
    .slave_gnt_o          (gnt),
    .slave_addr_i         (addr),
    .slave_we_i           (we),
    .slave_be_i           (be),
    .slave_wdata_i        (wdata),
    .slave_rvalid_o       (rvalid),
    .slave_rdata_o        (rdata),
    .slave_err_o          (err),
    .boot_select_i        (boot_sel),
    .execute_from_flash_i (exec_flash),
    .exit_valid_o         (exit_valid),
    .exit_value_o         (exit_value),
    .use_spimemio_o       (use_spi),
    .fast_intr_i          (fintr_in),
    .fast_intr_o          (fintr_out),
    .timer_intr_o         (tintr)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  task automatic abort_run();
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_eq(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("Fail at time %0t: %s is %h, expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  function automatic word_t reg_addr(word_t base, logic [WINDOW_BITS-1:0] ofs);
    return {base[31:WINDOW_BITS], ofs};
  endfunction

  function automatic logic in_window(word_t a, word_t base);
    return a[31:WINDOW_BITS] == base[31:WINDOW_BITS];
  endfunction

  function automatic logic is_mapped(word_t a);
    return in_window(a, SOC_CTRL_BASE) || in_window(a, TIMER_BASE) ||
           in_window(a, FAST_INTR_BASE);
  endfunction

  // Expands each enable bit to its byte lane
  function automatic word_t be_mask(be_t b);
    return {{8{b[3]}}, {8{b[2]}}, {8{b[1]}}, {8{b[0]}}};
  endfunction

  function automatic word_t model_read(word_t a);
    logic [WINDOW_BITS-1:0] ofs;
    word_t rd;
    ofs = a[WINDOW_BITS-1:0];
    rd = '0;
    if (in_window(a, SOC_CTRL_BASE)) begin
      case (ofs)
        SOC_EXIT_VALID_OFS:   rd = word_t'(m_exit_valid);
        SOC_EXIT_VALUE_OFS:   rd = m_exit_value;
        SOC_BOOT_SEL_OFS:     rd = word_t'(boot_sel);
        SOC_USE_SPIMEMIO_OFS: rd = word_t'(m_use_spi);
        default:              rd = '0;
      endcase
    end else if (in_window(a, TIMER_BASE)) begin
      // Count is only read this way while stopped at zero
      case (ofs)
        TMR_CTRL_OFS:     rd = word_t'(m_tmr_ctrl);
        TMR_PRESCALE_OFS: rd = word_t'(m_tmr_presc);
        TMR_COMPARE_OFS:  rd = m_tmr_cmp;
        TMR_STATUS_OFS:   rd = word_t'(m_tmr_status);
        default:          rd = '0;
      endcase
    end else if (in_window(a, FAST_INTR_BASE)) begin
      if (ofs == FIC_PENDING_OFS) rd = word_t'(m_fic_pend);
      if (ofs == FIC_ENABLE_OFS) rd = word_t'(m_fic_en);
    end
    return rd;
  endfunction

  task automatic model_commit(logic wr, word_t a, be_t b, word_t d);
    logic [WINDOW_BITS-1:0] ofs;
    word_t m;
    word_t clr;
    ofs = a[WINDOW_BITS-1:0];
    m = be_mask(b);
    clr = '0;
    if (wr && in_window(a, SOC_CTRL_BASE)) begin
      if (ofs == SOC_EXIT_VALID_OFS && b[0]) m_exit_valid = d[0];
      if (ofs == SOC_EXIT_VALUE_OFS) m_exit_value = (m_exit_value & ~m) | (d & m);
      if (ofs == SOC_USE_SPIMEMIO_OFS && b[0]) m_use_spi = d[0];
    end else if (wr && in_window(a, TIMER_BASE)) begin
      if (ofs == TMR_CTRL_OFS && b[0]) m_tmr_ctrl = d[1:0];
      if (ofs == TMR_PRESCALE_OFS) m_tmr_presc = (m_tmr_presc & ~m[15:0]) | (d[15:0] & m[15:0]);
      if (ofs == TMR_COMPARE_OFS) m_tmr_cmp = (m_tmr_cmp & ~m) | (d & m);
      if (ofs == TMR_STATUS_OFS && b[0] && d[0]) m_tmr_status = 1'b0;
    end else if (wr && in_window(a, FAST_INTR_BASE)) begin
      if (ofs == FIC_PENDING_OFS) clr = d & m;
      if (ofs == FIC_ENABLE_OFS) m_fic_en = (m_fic_en & ~m[14:0]) | (d[14:0] & m[14:0]);
    end
    // A line seen high wins over a clear in the same cycle
    m_fic_pend = (m_fic_pend & ~clr[14:0]) | nxt_fintr;
  endtask

  // One clock: check the previous response and the outputs, then drive
  task automatic cycle_step(input logic do_req, input logic do_we, input word_t a,
                            input be_t b, input word_t d, input logic chk);
    @(negedge clk);
    check_eq("slave_rvalid_o", word_t'(rvalid), word_t'(pend_valid));
    if (pend_valid) begin
      check_eq("slave_err_o", word_t'(err), word_t'(pend_err));
      if (pend_check) check_eq("slave_rdata_o", rdata, pend_rdata);
      last_rdata = rdata;
    end
    check_eq("exit_valid_o", word_t'(exit_valid), word_t'(m_exit_valid));
    check_eq("exit_value_o", exit_value, m_exit_value);
    check_eq("use_spimemio_o", word_t'(use_spi), word_t'(m_use_spi));
    check_eq("fast_intr_o", word_t'(fintr_out), word_t'(m_fic_pend & m_fic_en));
    boot_sel = nxt_boot;
    fintr_in = nxt_fintr;
    req = do_req;
    we = do_we;
    addr = a;
    be = b;
    wdata = d;
    pend_valid = do_req;
    pend_check = chk;
    pend_err = !is_mapped(a);
    pend_rdata = (do_we || !is_mapped(a)) ? '0 : model_read(a);
    model_commit(do_req && do_we && is_mapped(a), a, b, d);
    #1;
    check_eq("slave_gnt_o", word_t'(gnt), word_t'(do_req));
  endtask

  task automatic read_reg(input word_t base, input logic [WINDOW_BITS-1:0] ofs);
    cycle_step(1'b1, 1'b0, reg_addr(base, ofs), 4'hF, '0, 1'b1);
  endtask

  function automatic word_t pick_addr(logic [3:0] sel, word_t rnd);
    word_t a;
    case (sel)
      4'd0:              a = reg_addr(SOC_CTRL_BASE, SOC_EXIT_VALID_OFS);
      4'd1, 4'd8, 4'd15: a = reg_addr(SOC_CTRL_BASE, SOC_EXIT_VALUE_OFS);
      4'd2:              a = reg_addr(SOC_CTRL_BASE, SOC_BOOT_SEL_OFS);
      4'd3:              a = reg_addr(SOC_CTRL_BASE, SOC_USE_SPIMEMIO_OFS);
      4'd4, 4'd13:       a = reg_addr(FAST_INTR_BASE, FIC_ENABLE_OFS);
      4'd5, 4'd14:       a = reg_addr(TIMER_BASE, TMR_PRESCALE_OFS);
      4'd6, 4'd9:        a = reg_addr(TIMER_BASE, TMR_COMPARE_OFS);
      4'd7:              a = reg_addr(TIMER_BASE, 12'h0F0);
      default: begin
        // Outside all three windows
        a = rnd;
        if (a[31:WINDOW_BITS] < 20'd3) a[31] = 1'b1;
      end
    endcase
    return a;
  endfunction

  task automatic timer_run();
    word_t r;
    int    cmp;
    int    presc;
    int    limit;
    int    k;
    r = $random(seed);
    cmp = int'(r[3:0]) + 2;
    presc = int'(r[5:4]);
    limit = cmp * (presc + 1);
    cycle_step(1'b1, 1'b1, reg_addr(TIMER_BASE, TMR_COUNT_OFS), 4'hF, '0, 1'b1);
    cycle_step(1'b1, 1'b1, reg_addr(TIMER_BASE, TMR_PRESCALE_OFS), 4'h3, word_t'(presc), 1'b1);
    cycle_step(1'b1, 1'b1, reg_addr(TIMER_BASE, TMR_COMPARE_OFS), 4'hF, word_t'(cmp), 1'b1);
    cycle_step(1'b1, 1'b1, reg_addr(TIMER_BASE, TMR_CTRL_OFS), 4'h1, 32'h3, 1'b1);
    k = 1;
    cycle_step(1'b0, 1'b0, '0, '0, '0, 1'b1);
    while (!tintr) begin
      if (k >= limit + 4) begin
        $display("Timer interrupt did not rise within %0d cycles", limit + 4);
        abort_run();
      end
      cycle_step(1'b0, 1'b0, '0, '0, '0, 1'b1);
      k++;
    end
    if (k <= limit) begin
      $display("Timer interrupt rose after %0d cycles, before %0d", k, limit);
      abort_run();
    end
    m_tmr_status = 1'b1;
    read_reg(TIMER_BASE, TMR_STATUS_OFS);
    cycle_step(1'b1, 1'b0, reg_addr(TIMER_BASE, TMR_COUNT_OFS), 4'hF, '0, 1'b0);
    cycle_step(1'b1, 1'b1, reg_addr(TIMER_BASE, TMR_STATUS_OFS), 4'h1, 32'h1, 1'b1);
    check_eq("count >= compare", word_t'(last_rdata >= word_t'(cmp)), 32'd1);
    cycle_step(1'b1, 1'b1, reg_addr(TIMER_BASE, TMR_CTRL_OFS), 4'h1, '0, 1'b1);
    check_eq("timer_intr_o", word_t'(tintr), 32'd0);
  endtask

  initial begin
    repeat (N_ACCESS * 4 + TIMER_BUDGET) @(posedge clk);
    $display("Watchdog expired before the tests completed");
    abort_run();
  end

  initial begin
    word_t r;
    word_t r2;
    seed = 32'h7412_c4f1;
    r = $random(seed);
    rst = 1'b1;
    req = 1'b0;
    addr = '0;
    we = 1'b0;
    be = '0;
    wdata = '0;
    fintr_in = '0;
    exec_flash = r[0];
    boot_sel = r[1];
    nxt_boot = r[1];
    nxt_fintr = '0;
    m_exit_valid = 1'b0;
    m_exit_value = '0;
    m_use_spi = r[0];
    m_fic_pend = '0;
    m_fic_en = '0;
    m_tmr_ctrl = '0;
    m_tmr_presc = '0;
    m_tmr_cmp = '0;
    m_tmr_status = 1'b0;
    pend_valid = 1'b0;
    pend_check = 1'b0;
    pend_err = 1'b0;
    pend_rdata = '0;
    last_rdata = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    // Strap is only sampled during reset
    exec_flash = ~exec_flash;
    check_eq("timer_intr_o", word_t'(tintr), 32'd0);
    check_eq("slave_err_o", word_t'(err), 32'd0);
    read_reg(SOC_CTRL_BASE, SOC_EXIT_VALID_OFS);
    read_reg(SOC_CTRL_BASE, SOC_EXIT_VALUE_OFS);
    read_reg(SOC_CTRL_BASE, SOC_BOOT_SEL_OFS);
    read_reg(SOC_CTRL_BASE, SOC_USE_SPIMEMIO_OFS);
    read_reg(TIMER_BASE, TMR_CTRL_OFS);
    read_reg(TIMER_BASE, TMR_PRESCALE_OFS);
    read_reg(TIMER_BASE, TMR_COMPARE_OFS);
    read_reg(TIMER_BASE, TMR_COUNT_OFS);
    read_reg(TIMER_BASE, TMR_STATUS_OFS);
    read_reg(FAST_INTR_BASE, FIC_PENDING_OFS);
    read_reg(FAST_INTR_BASE, FIC_ENABLE_OFS);

    for (int i = 0; i < N_RAND; i++) begin
      r = $random(seed);
      r2 = $random(seed);
      nxt_boot = r[12];
      cycle_step(r[4] | r[5] | r[6], r[7], pick_addr(r[3:0], r2), r[11:8], $random(seed), 1'b1);
    end

    for (int i = 0; i < N_BOOT; i++) begin
      r = $random(seed);
      nxt_boot = r[0];
      read_reg(SOC_CTRL_BASE, SOC_BOOT_SEL_OFS);
    end

    // Sparse pulses on the fast lines mixed with clears and mask updates
    for (int i = 0; i < N_FIC; i++) begin
      r = $random(seed);
      r2 = $random(seed);
      nxt_fintr = r[14:0] & r[30:16] & {15{r[31]}};
      cycle_step(r2[31], r2[30],
                 reg_addr(FAST_INTR_BASE, r2[29] ? FIC_PENDING_OFS : FIC_ENABLE_OFS),
                 r2[19:16], $random(seed), 1'b1);
    end
    nxt_fintr = '0;

    timer_run();
    cycle_step(1'b0, 1'b0, '0, '0, '0, 1'b1);
    $display("Testbench passed");
    $finish;
  end

endmodule : ao_peripheral_subsystem_tb

// File: filelist.f
logic/ao_periph_pkg.sv
logic/obi_reg_bridge.sv
logic/ao_reg_demux.sv
logic/soc_ctrl.sv
logic/fast_intr_ctrl.sv
logic/timer_regs.sv
logic/timer_core.sv
logic/ao_peripheral_subsystem.sv
bench/ao_peripheral_subsystem_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the always-on peripheral subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps \
  -f filelist.f \
  --top-module ao_peripheral_subsystem_tb \
  -o ao_sim

# The log decides the result, so a failing run still reaches the search
./obj_dir/ao_sim | tee sim.log

if grep -q "Testbench passed" sim.log; then
  echo "Simulation PASS"
  exit 0
else
  echo "Simulation FAIL"
  exit 1
fi
